//--- Makefile
# Verilator build and run for the cache bus subsystem

VERILATOR ?= verilator
TOP       ?= cache_bus_tb
RTL_TOP   ?= cache_bus_top
TB_SRC    ?= cache_bus_tb.sv
FILELIST  ?= cache_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --timing

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter-out $(TB_SRC),$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

build: $(SIM_BIN)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ahb3lite_pkg.sv
// AHB3-Lite encodings and the address phase bundle
// shared by the bus master and the SRAM slave

package ahb3lite_pkg;

  //////////////////////////////
  // transfer encodings
  //////////////////////////////
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } hburst_t;

  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_t;

  // hprot bits, or'ed together
  localparam logic [3:0] HPROT_OPCODE         = 4'b0000;
  localparam logic [3:0] HPROT_DATA           = 4'b0001;
  localparam logic [3:0] HPROT_USER           = 4'b0000;
  localparam logic [3:0] HPROT_PRIVILEGED     = 4'b0010;
  localparam logic [3:0] HPROT_NON_BUFFERABLE = 4'b0000;
  localparam logic [3:0] HPROT_BUFFERABLE     = 4'b0100;
  localparam logic [3:0] HPROT_NON_CACHEABLE  = 4'b0000;
  localparam logic [3:0] HPROT_CACHEABLE      = 4'b1000;

  //////////////////////////////
  // address phase
  //////////////////////////////
  typedef struct packed {
    logic [31:0] haddr;
    logic        hwrite;
    hsize_t      hsize;
    hburst_t     hburst;
    logic [3:0]  hprot;  // see HPROT_*
    htrans_t     htrans;
  } ahb_addr_t;

endpackage

//--- ahb3lite_sram.sv
// AHB3-Lite SRAM slave with byte lanes, a periodic wait state and
// error responses for out of range and user access to the privileged window

`timescale 1ns/1ps

module ahb3lite_sram (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  ahb3lite_pkg::ahb_addr_t          ahb,
  input  logic [cache_bus_pkg::XLEN-1:0]   HWDATA,
  output logic [cache_bus_pkg::XLEN-1:0]   HRDATA,
  output logic                             HREADY,
  output ahb3lite_pkg::hresp_t             HRESP
);
  import ahb3lite_pkg::*;
  import cache_bus_pkg::*;

  logic [XLEN-1:0]                  mem [SRAM_WORDS];  // aliases every 1 KB
  logic                             addr_xfer;
  logic                             addr_err;
  logic                             dph_valid;  // data phase in progress
  logic                             d_err;
  logic                             d_write;
  logic [PADDR-1:0]                 d_addr;
  hsize_t                           d_size;
  logic [XLEN/8-1:0]                lanes;
  logic [$clog2(SRAM_WORDS)-1:0]    mem_idx;
  logic [$clog2(WAIT_EVERY)-1:0]    wait_cnt;

  //////////////////////////////
  // address decode
  //////////////////////////////
  assign addr_xfer = (ahb.htrans == HTRANS_NONSEQ) || (ahb.htrans == HTRANS_SEQ);
  assign addr_err  = (ahb.haddr >= SRAM_LIMIT) ||
                     ((ahb.hprot & HPROT_PRIVILEGED) == HPROT_USER &&
                      ahb.haddr >= PRIV_BASE);

  // response: ok, one wait cycle, or two cycle error
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      dph_valid <= 1'b0;
      d_err     <= 1'b0;
      wait_cnt  <= '0;
      HREADY    <= 1'b1;
      HRESP     <= HRESP_OKAY;
    end
    else if (!HREADY)
      HREADY <= 1'b1;  // end of wait, or second error cycle (hresp holds)
    else
    begin
      dph_valid <= addr_xfer;
      d_err     <= addr_xfer && addr_err;
      HRESP     <= HRESP_OKAY;
      if (addr_xfer && addr_err)
      begin
        HREADY <= 1'b0;
        HRESP  <= HRESP_ERROR;
      end
      else if (addr_xfer)
      begin
        if (wait_cnt == WAIT_EVERY-1)
        begin
          wait_cnt <= '0;
          HREADY   <= 1'b0;
        end
        else
          wait_cnt <= wait_cnt + 1'b1;
      end
    end

  //////////////////////////////
  // storage
  //////////////////////////////
  always_comb
    case (d_size)
      HSIZE_BYTE:  lanes = 4'b0001 << d_addr[1:0];
      HSIZE_HWORD: lanes = d_addr[1] ? 4'b1100 : 4'b0011;
      default:     lanes = 4'b1111;
    endcase

  assign mem_idx = d_addr[$clog2(SRAM_WORDS)+1:2];
  assign HRDATA  = mem[mem_idx];  // whole word, master picks lanes

  always_ff @(posedge HCLK)
    if (HREADY)
    begin
      if (dph_valid && d_write && !d_err)  // data phase completes now
        for (int i = 0; i < XLEN/8; i++)
          if (lanes[i]) mem[mem_idx][i*8 +: 8] <= HWDATA[i*8 +: 8];
      if (addr_xfer)
      begin
        d_addr  <= ahb.haddr;
        d_write <= ahb.hwrite;
        d_size  <= ahb.hsize;
      end
    end

endmodule

//--- cache_biu_ahb3lite.sv
// AHB3-Lite master for the cache that turns strobe requests into single or
// burst transfers and returns per-beat acknowledges and bus errors

`timescale 1ns/1ps

module cache_biu_ahb3lite (
  input  logic                                HCLK,
  input  logic                                HRESETn,

  // ahb side
  output ahb3lite_pkg::ahb_addr_t             ahb,
  input  logic [cache_bus_pkg::XLEN-1:0]      HRDATA,
  output logic [cache_bus_pkg::XLEN-1:0]      HWDATA,
  input  logic                                HREADY,
  input  ahb3lite_pkg::hresp_t                HRESP,

  // line controller side
  input  logic                                biu_stb,
  output logic                                biu_stb_ack,
  input  logic [cache_bus_pkg::PADDR-1:0]     biu_adri,
  output logic [cache_bus_pkg::PADDR-1:0]     biu_adro,
  input  logic [cache_bus_pkg::XLEN/8-1:0]    biu_be,
  input  ahb3lite_pkg::hburst_t               biu_type,
  input  logic                                biu_we,
  input  logic [cache_bus_pkg::XLEN-1:0]      biu_di,
  output logic [cache_bus_pkg::XLEN-1:0]      biu_do,
  output logic                                biu_wack,  // write beat done
  output logic                                biu_rack,  // biu_do valid
  output logic                                biu_err,
  input  logic                                biu_is_cacheable,
  input  logic                                biu_is_instruction,
  input  cache_bus_pkg::prv_t                 biu_prv
);
  import ahb3lite_pkg::*;
  import cache_bus_pkg::*;

  logic [3:0] burst_cnt;  // beats still to issue after current
  logic       data_ena;   // address phase on the bus is a real transfer
  logic       ddata_ena;  // data_ena delayed by one hready (data phase)
  logic       dhwrite;
  logic       dph_ok;

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic hsize_t be2hsize(input logic [XLEN/8-1:0] be);
    case (be)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: be2hsize = HSIZE_BYTE;
      4'b0011, 4'b1100:                   be2hsize = HSIZE_HWORD;
      default:                            be2hsize = HSIZE_WORD;
    endcase
  endfunction

  // low address bits implied by the lanes
  function automatic logic [1:0] be2off(input logic [XLEN/8-1:0] be);
    case (be)
      4'b0010:          be2off = 2'd1;
      4'b0100, 4'b1100: be2off = 2'd2;
      4'b1000:          be2off = 2'd3;
      default:          be2off = 2'd0;
    endcase
  endfunction

  // beats minus one
  function automatic logic [3:0] type2cnt(input hburst_t btype);
    case (btype)
      HBURST_WRAP4, HBURST_INCR4:   type2cnt = 4'd3;
      HBURST_WRAP8, HBURST_INCR8:   type2cnt = 4'd7;
      HBURST_WRAP16, HBURST_INCR16: type2cnt = 4'd15;
      default:                      type2cnt = 4'd0;
    endcase
  endfunction

  function automatic logic [PADDR-1:0] nxt_addr(input logic [PADDR-1:0] addr,
                                                input hburst_t          hburst);
    logic [PADDR-1:0] lin;
    lin = {addr[PADDR-1:2] + 1'b1, 2'b00};  // linear next word
    case (hburst)
      HBURST_WRAP4:  nxt_addr = {addr[PADDR-1:4], lin[3:0]};
      HBURST_WRAP8:  nxt_addr = {addr[PADDR-1:5], lin[4:0]};
      HBURST_WRAP16: nxt_addr = {addr[PADDR-1:6], lin[5:0]};
      default:       nxt_addr = lin;
    endcase
  endfunction

  //////////////////////////////
  // address phase
  //////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      data_ena   <= 1'b0;
      biu_err    <= 1'b0;
      burst_cnt  <= '0;
      ahb.haddr  <= '0;
      ahb.hwrite <= 1'b0;
      ahb.hsize  <= HSIZE_WORD;
      ahb.hburst <= HBURST_SINGLE;
      ahb.hprot  <= HPROT_DATA | HPROT_PRIVILEGED;
      ahb.htrans <= HTRANS_IDLE;
    end
    else
    begin
      biu_err <= 1'b0;  // single cycle pulse

      if (HREADY)
      begin
        if (burst_cnt == '0)
        begin
          if (biu_stb && !biu_err)  // new request, NONSEQ
          begin
            data_ena   <= 1'b1;
            burst_cnt  <= type2cnt(biu_type);
            ahb.htrans <= HTRANS_NONSEQ;
            ahb.haddr  <= {biu_adri[PADDR-1:2], be2off(biu_be)};
            ahb.hwrite <= biu_we;
            ahb.hsize  <= be2hsize(biu_be);
            ahb.hburst <= biu_type;
            ahb.hprot  <= (biu_prv == PRV_U ? HPROT_USER   : HPROT_PRIVILEGED) |
                          (biu_is_instruction ? HPROT_OPCODE : HPROT_DATA) |
                          (biu_is_cacheable ? (HPROT_CACHEABLE | HPROT_BUFFERABLE)
                                            : (HPROT_NON_CACHEABLE | HPROT_NON_BUFFERABLE));
          end
          else
          begin
            data_ena   <= 1'b0;
            ahb.htrans <= HTRANS_IDLE;
          end
        end
        else
        begin
          data_ena   <= 1'b1;
          burst_cnt  <= burst_cnt - 1'b1;
          ahb.htrans <= HTRANS_SEQ;
          ahb.haddr  <= nxt_addr(ahb.haddr, ahb.hburst);
        end
      end
      else if (HRESP == HRESP_ERROR)
      begin
        // drop the rest of the burst in the first error cycle
        burst_cnt  <= '0;
        ahb.htrans <= HTRANS_IDLE;
        data_ena   <= 1'b0;
        biu_err    <= 1'b1;
      end
    end

  //////////////////////////////
  // data phase
  //////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)    ddata_ena <= 1'b0;
    else if (HREADY) ddata_ena <= data_ena;

  always_ff @(posedge HCLK)
    if (HREADY)
    begin
      dhwrite  <= ahb.hwrite;
      biu_adro <= ahb.haddr;  // address of the beat now in data phase
    end

  assign dph_ok      = HREADY & ddata_ena & (HRESP == HRESP_OKAY);
  assign biu_wack    = dph_ok &  dhwrite;
  assign biu_rack    = dph_ok & ~dhwrite;
  assign biu_do      = HRDATA;
  assign HWDATA      = biu_di;  // controller moves to next word on wack
  assign biu_stb_ack = HREADY & (burst_cnt == '0) & biu_stb & ~biu_err;

  // a single transfer never gets a SEQ beat
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    ahb.htrans == HTRANS_SEQ |-> ahb.hburst != HBURST_SINGLE);

  // controller only ever asks for naturally aligned lanes
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    biu_stb |-> biu_be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                               4'b0011, 4'b1100, 4'b1111});

endmodule

//--- cache_bus.f
ahb3lite_pkg.sv
cache_bus_pkg.sv
cache_biu_ahb3lite.sv
cache_line_ctrl.sv
ahb3lite_sram.sv
cache_bus_top.sv
cache_bus_tb.sv

//--- cache_bus_pkg.sv
// Cache side definitions: privilege, request opcodes, line geometry,
// request/response bundles and the SRAM slave map

package cache_bus_pkg;

  localparam int XLEN       = 32;  // data width
  localparam int PADDR      = 32;  // physical address width
  localparam int LINE_WORDS = 4;   // one WRAP4 burst per line

  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } prv_t;

  typedef enum logic [1:0] {
    OP_FILL      = 2'b00,  // line read
    OP_WRITEBACK = 2'b01,  // line write
    OP_READ      = 2'b10,  // uncached single
    OP_WRITE     = 2'b11
  } cache_op_t;

  typedef struct packed {
    cache_op_t                    op;
    logic [PADDR-1:0]             addr;
    logic [XLEN/8-1:0]            be;     // single ops only
    prv_t                         prv;
    logic                         is_instruction;
    logic                         cacheable;
    logic [LINE_WORDS*XLEN-1:0]   wline;  // word i at bits i*XLEN up
  } cache_req_t;

  typedef struct packed {
    logic [LINE_WORDS*XLEN-1:0] rline;  // single read lands in slot 0
    logic                       err;
  } cache_rsp_t;

  //////////////////////////////
  // sram slave map
  //////////////////////////////
  localparam int          SRAM_WORDS = 256;
  localparam logic [31:0] PRIV_BASE  = 32'h0000_0800;  // privileged window
  localparam logic [31:0] SRAM_LIMIT = 32'h0000_1000;  // error at or above
  localparam int          WAIT_EVERY = 3;               // one wait per n phases

endpackage

//--- cache_bus_stimulus.txt
# columns: name op addr be prv wdata0 wdata1 wdata2 wdata3 rdata0 rdata1 rdata2 rdata3 err
# op is FILL, WB, RD or WR; prv 0 user, 3 machine; single ops use slot 0; values in hex
t1_clr WB 00000000 f 3 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
t1_fill FILL 00000008 f 3 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
t2_wb WB 00000044 f 3 10000000 21111111 32222222 43333333 00000000 00000000 00000000 00000000 0
t2_fill8 FILL 00000048 f 3 00000000 00000000 00000000 00000000 10000000 21111111 32222222 43333333 0
t2_fillc FILL 0000004c f 3 00000000 00000000 00000000 00000000 10000000 21111111 32222222 43333333 0
t3_word WR 00000100 f 3 11223344 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
t3_byte WR 00000101 2 3 0000aa00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
t3_half WR 00000102 c 3 beef0000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
t3_read RD 00000100 f 3 00000000 00000000 00000000 00000000 beefaa44 00000000 00000000 00000000 0
t4_rd_oor RD 00001004 f 3 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1
t4_fl_oor FILL 00001010 f 3 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1
t4_rd_ok RD 00000100 f 3 00000000 00000000 00000000 00000000 beefaa44 00000000 00000000 00000000 0
t4_fl_ok FILL 00000040 f 3 00000000 00000000 00000000 00000000 10000000 21111111 32222222 43333333 0
t5_m_wr WR 00000800 f 3 cafef00d 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
t5_u_wr WR 00000800 f 0 0badbeef 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1
t5_m_rd RD 00000800 f 3 00000000 00000000 00000000 00000000 cafef00d 00000000 00000000 00000000 0
t5_u_rd RD 00000800 f 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1
t5_u_low RD 00000100 f 0 00000000 00000000 00000000 00000000 beefaa44 00000000 00000000 00000000 0

//--- cache_bus_tb.sv
// Testbench for the cache bus subsystem
// replays file driven requests against a word model and adds random line traffic

`timescale 1ns/1ps

module cache_bus_tb;
  import cache_bus_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;  // per wait loop
  localparam int RAND_LINES     = 10;   // write-back + fill pairs
  localparam int DRIVE_DELAY    = 5;    // after rising edge

  logic       HCLK;
  logic       HRESETn;
  cache_req_t req;
  logic       req_valid;
  logic       req_ready;
  cache_rsp_t rsp;
  logic       rsp_valid;

  logic [XLEN-1:0] model [SRAM_WORDS];  // expected sram words
  logic [31:0]     lcg_state;
  int              ops_done;

  cache_bus_top dut_i (
    .HCLK, .HRESETn,
    .req, .req_valid, .req_ready, .rsp, .rsp_valid
  );

  initial
  begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;  // 100 ns period
  end

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // slave decodes only enough bits for SRAM_WORDS words
  function automatic int word_index(input logic [PADDR-1:0] addr);
    return int'(addr[PADDR-1:2]) % SRAM_WORDS;
  endfunction

  function automatic logic map_error(input logic [PADDR-1:0] addr, input prv_t prv);
    return (addr >= SRAM_LIMIT) || (prv == PRV_U && addr >= PRIV_BASE);
  endfunction

  function automatic int read_slots(input cache_op_t op);
    if (op == OP_FILL)
      return LINE_WORDS;
    else if (op == OP_READ)
      return 1;  // slot 0 only
    else
      return 0;
  endfunction

  function automatic logic [LINE_WORDS*XLEN-1:0] predict_line(input cache_req_t r);
    logic [LINE_WORDS*XLEN-1:0] line;
    int                         base;
    line = '0;
    base = word_index({r.addr[PADDR-1:4], 4'h0});  // first word of the line
    if (r.op == OP_FILL)
      for (int i = 0; i < LINE_WORDS; i++)
        line[i*XLEN +: XLEN] = model[(base + i) % SRAM_WORDS];
    else
      line[XLEN-1:0] = model[word_index(r.addr)];
    return line;
  endfunction

  task automatic update_model(input cache_req_t r);
    int base;
    int idx;
    base = word_index({r.addr[PADDR-1:4], 4'h0});
    idx  = word_index(r.addr);
    if (r.op == OP_WRITEBACK)
      for (int i = 0; i < LINE_WORDS; i++)
        model[(base + i) % SRAM_WORDS] = r.wline[i*XLEN +: XLEN];
    else
      for (int b = 0; b < XLEN/8; b++)
        if (r.be[b]) model[idx][b*8 +: 8] = r.wline[b*8 +: 8];  // lane merge
  endtask

  //////////////////////////////
  // reporting
  //////////////////////////////
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_value(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
    stop_run($sformatf("Fail %s: expected %h, actual %h", test, exp, act));
  endtask

  //////////////////////////////
  // request port
  //////////////////////////////
  task automatic issue_request(input string test, input cache_req_t r,
                               output cache_rsp_t got);
    int n;
    n = 0;
    while (req_ready !== 1'b1)
    begin
      @(posedge HCLK);
      #DRIVE_DELAY;
      n++;
      if (n >= TIMEOUT_CYCLES)
        stop_run($sformatf("%s: req_ready never came back", test));
    end
    req       = r;
    req_valid = 1'b1;
    @(posedge HCLK);  // transfer edge
    #DRIVE_DELAY;
    req_valid = 1'b0;
    n = 0;
    while (rsp_valid !== 1'b1)
    begin
      @(posedge HCLK);
      #DRIVE_DELAY;
      n++;
      if (n >= TIMEOUT_CYCLES)
        stop_run($sformatf("%s: no response within %0d cycles", test, TIMEOUT_CYCLES));
    end
    got = rsp;  // stable until next edge
    ops_done++;
    @(posedge HCLK);
    #DRIVE_DELAY;
    // response is a one cycle pulse and the port is free again
    assert (rsp_valid === 1'b0)
      else report_value({test, " rsp_valid pulse"}, 32'd0, {31'd0, rsp_valid});
    assert (req_ready === 1'b1)
      else report_value({test, " req_ready after rsp"}, 32'd1, {31'd0, req_ready});
  endtask

  task automatic check_response(input string test, input cache_req_t r,
                                input logic [LINE_WORDS*XLEN-1:0] exp_line,
                                input logic exp_err, input cache_rsp_t got);
    logic [XLEN-1:0] e;
    logic [XLEN-1:0] a;
    assert (got.err === exp_err)
      else report_value({test, " err"}, {31'd0, exp_err}, {31'd0, got.err});
    if (!exp_err)
    begin
      for (int i = 0; i < read_slots(r.op); i++)
      begin
        e = exp_line[i*XLEN +: XLEN];
        a = got.rline[i*XLEN +: XLEN];
        assert (a === e) else report_value($sformatf("%s slot %0d", test, i), e, a);
      end
      if (r.op == OP_WRITEBACK || r.op == OP_WRITE)
        update_model(r);  // only writes that completed
    end
  endtask

  //////////////////////////////
  // stimulus file
  //////////////////////////////
  task automatic replay_stimulus_file();
    int                         fd;
    int                         code;
    string                      name;
    string                      op_name;
    string                      rest;
    logic [31:0]                addr;
    logic [3:0]                 be;
    logic [1:0]                 prv_raw;
    logic [31:0]                wd [LINE_WORDS];
    logic [31:0]                rd [LINE_WORDS];
    logic                       exp_err;
    logic [LINE_WORDS*XLEN-1:0] exp_line;
    logic [LINE_WORDS*XLEN-1:0] model_line;
    cache_req_t                 r;
    cache_rsp_t                 got;
    fd = $fopen("cache_bus_stimulus.txt", "r");
    if (fd == 0)
      stop_run("could not open cache_bus_stimulus.txt");
    while ($fscanf(fd, "%s", name) == 1)
    begin
      if (name.getc(0) == "#")
        code = $fgets(rest, fd);  // skip comment
      else
      begin
        code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h", op_name, addr, be,
                       prv_raw, wd[0], wd[1], wd[2], wd[3], rd[0], rd[1], rd[2], rd[3],
                       exp_err);
        if (code != 13)
          stop_run($sformatf("stimulus line %s is missing fields", name));
        r = '0;
        case (op_name)
          "FILL":  r.op = OP_FILL;
          "WB":    r.op = OP_WRITEBACK;
          "RD":    r.op = OP_READ;
          "WR":    r.op = OP_WRITE;
          default: stop_run($sformatf("stimulus line %s has unknown opcode %s", name, op_name));
        endcase
        r.addr      = addr;
        r.be        = be;
        r.prv       = prv_t'(prv_raw);
        r.cacheable = (r.op == OP_FILL) || (r.op == OP_WRITEBACK);
        for (int i = 0; i < LINE_WORDS; i++)
        begin
          r.wline[i*XLEN +: XLEN]  = wd[i];
          exp_line[i*XLEN +: XLEN] = rd[i];
        end
        // file values against map and model
        assert (map_error(addr, r.prv) === exp_err)
          else stop_run($sformatf("stimulus %s: error flag disagrees with the address map",
                                  name));
        if (!exp_err)
        begin
          model_line = predict_line(r);
          for (int i = 0; i < read_slots(r.op); i++)
            assert (exp_line[i*XLEN +: XLEN] === model_line[i*XLEN +: XLEN])
              else stop_run($sformatf("stimulus %s: stale expected data in slot %0d", name, i));
        end
        issue_request(name, r, got);
        check_response(name, r, exp_line, exp_err, got);
      end
    end
    $fclose(fd);
  endtask

  // write-back then fill of the same line from another word without idle gap
  task automatic random_line_traffic();
    cache_req_t  r;
    cache_rsp_t  got;
    logic [31:0] rnd;
    string       name;
    for (int k = 0; k < RAND_LINES; k++)
    begin
      r           = '0;
      r.op        = OP_WRITEBACK;
      r.addr      = next_random() & 32'h0000_03fc;  // any word in the low kilobyte
      r.be        = '1;
      r.prv       = PRV_M;
      r.cacheable = 1'b1;
      for (int i = 0; i < LINE_WORDS; i++)
        r.wline[i*XLEN +: XLEN] = next_random();
      name = $sformatf("rand%0d_wb", k);
      issue_request(name, r, got);
      check_response(name, r, '0, 1'b0, got);
      rnd              = next_random();
      r.op             = OP_FILL;
      r.addr           = {r.addr[PADDR-1:4], rnd[3:2], 2'b00};  // new critical word
      r.is_instruction = rnd[4];
      r.wline          = '0;
      name = $sformatf("rand%0d_fill", k);
      issue_request(name, r, got);
      check_response(name, r, predict_line(r), 1'b0, got);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial
  begin
    HRESETn   = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    lcg_state = 32'h8bfa_9d43;
    ops_done  = 0;
    foreach (model[i])
      model[i] = '0;
    repeat (2) @(posedge HCLK);
    #DRIVE_DELAY;
    HRESETn = 1'b1;
    assert (req_ready === 1'b1)
      else report_value("reset req_ready", 32'd1, {31'd0, req_ready});
    assert (rsp_valid === 1'b0)
      else report_value("reset rsp_valid", 32'd0, {31'd0, rsp_valid});
    replay_stimulus_file();
    random_line_traffic();
    if (ops_done > 2 * RAND_LINES)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
      stop_run("the stimulus file held no requests");
  end

endmodule

//--- cache_bus_top.sv
// Cache bus subsystem: line controller, AHB3-Lite master and SRAM slave

`timescale 1ns/1ps

module cache_bus_top (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  cache_bus_pkg::cache_req_t   req,
  input  logic                        req_valid,
  output logic                        req_ready,
  output cache_bus_pkg::cache_rsp_t   rsp,
  output logic                        rsp_valid
);
  import ahb3lite_pkg::*;
  import cache_bus_pkg::*;

  // controller <-> biu
  logic              biu_stb, biu_stb_ack;
  logic [PADDR-1:0]  biu_adri, biu_adro;
  logic [XLEN/8-1:0] biu_be;
  hburst_t           biu_type;
  logic              biu_we;
  logic [XLEN-1:0]   biu_di, biu_do;
  logic              biu_wack, biu_rack, biu_err;
  logic              biu_is_cacheable, biu_is_instruction;
  prv_t              biu_prv;

  // ahb
  ahb_addr_t         ahb;
  logic [XLEN-1:0]   HWDATA, HRDATA;
  logic              HREADY;  // shared master/slave
  hresp_t            HRESP;

  cache_line_ctrl ctrl_i (
    .HCLK, .HRESETn,
    .req, .req_valid, .req_ready, .rsp, .rsp_valid,
    .biu_stb, .biu_stb_ack, .biu_adri, .biu_adro, .biu_be, .biu_type,
    .biu_we, .biu_di, .biu_do, .biu_wack, .biu_rack, .biu_err,
    .biu_is_cacheable, .biu_is_instruction, .biu_prv
  );

  cache_biu_ahb3lite biu_i (
    .HCLK, .HRESETn,
    .ahb, .HRDATA, .HWDATA, .HREADY, .HRESP,
    .biu_stb, .biu_stb_ack, .biu_adri, .biu_adro, .biu_be, .biu_type,
    .biu_we, .biu_di, .biu_do, .biu_wack, .biu_rack, .biu_err,
    .biu_is_cacheable, .biu_is_instruction, .biu_prv
  );

  ahb3lite_sram sram_i (
    .HCLK, .HRESETn,
    .ahb, .HWDATA, .HRDATA, .HREADY, .HRESP
  );

endmodule

//--- cache_line_ctrl.sv
// Cache request sequencer that turns line and single requests into bus
// strobes, orders write words critical first and gathers read words by slot

`timescale 1ns/1ps

module cache_line_ctrl (
  input  logic                                HCLK,
  input  logic                                HRESETn,

  // request port
  input  cache_bus_pkg::cache_req_t           req,
  input  logic                                req_valid,
  output logic                                req_ready,
  output cache_bus_pkg::cache_rsp_t           rsp,
  output logic                                rsp_valid,

  // bus interface unit
  output logic                                biu_stb,
  input  logic                                biu_stb_ack,
  output logic [cache_bus_pkg::PADDR-1:0]     biu_adri,
  input  logic [cache_bus_pkg::PADDR-1:0]     biu_adro,
  output logic [cache_bus_pkg::XLEN/8-1:0]    biu_be,
  output ahb3lite_pkg::hburst_t               biu_type,
  output logic                                biu_we,
  output logic [cache_bus_pkg::XLEN-1:0]      biu_di,
  input  logic [cache_bus_pkg::XLEN-1:0]      biu_do,
  input  logic                                biu_wack,
  input  logic                                biu_rack,
  input  logic                                biu_err,
  output logic                                biu_is_cacheable,
  output logic                                biu_is_instruction,
  output cache_bus_pkg::prv_t                 biu_prv
);
  import ahb3lite_pkg::*;
  import cache_bus_pkg::*;

  typedef enum logic [1:0] {IDLE, REQ, BEATS, DONE} state_t;

  state_t                          state;
  cache_req_t                      req_q;       // latched request
  logic [LINE_WORDS*XLEN-1:0]      rline_q;
  logic                            err_q;
  logic [$clog2(LINE_WORDS)-1:0]   beats_left;
  logic [$clog2(LINE_WORDS)-1:0]   wptr;        // next write word
  logic [$clog2(LINE_WORDS)-1:0]   rslot;
  logic                            line_op;

  function automatic logic is_line(input cache_op_t op);
    is_line = (op == OP_FILL) || (op == OP_WRITEBACK);
  endfunction

  assign line_op = is_line(req_q.op);
  assign rslot   = line_op ? biu_adro[3:2] : '0;

  //////////////////////////////
  // sequencer
  //////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      state      <= IDLE;
      beats_left <= '0;
      wptr       <= '0;
      err_q      <= 1'b0;
    end
    else
      case (state)
        IDLE:
          if (req_valid)
          begin
            state      <= REQ;
            beats_left <= is_line(req.op) ? '1 : '0;    // LINE_WORDS-1 as all ones
            wptr       <= is_line(req.op) ? req.addr[3:2] : '0;  // critical word
            err_q      <= 1'b0;
          end
        REQ:
          if (biu_stb_ack) state <= BEATS;
        BEATS:
          if (biu_err)
          begin
            err_q <= 1'b1;  // unit already dropped the burst
            state <= DONE;
          end
          else if (biu_rack || biu_wack)
          begin
            if (biu_wack) wptr <= wptr + 1'b1;  // wraps inside the line
            if (beats_left == '0) state <= DONE;
            else beats_left <= beats_left - 1'b1;
          end
        default:
          state <= IDLE;  // response shown for one cycle in DONE
      endcase

  // payload
  always_ff @(posedge HCLK)
  begin
    if (state == IDLE && req_valid)
    begin
      req_q   <= req;
      rline_q <= '0;
    end
    if (state == BEATS && biu_rack)
      rline_q[rslot*XLEN +: XLEN] <= biu_do;
  end

  //////////////////////////////
  // outputs
  //////////////////////////////
  assign req_ready = (state == IDLE);
  assign rsp_valid = (state == DONE);
  assign rsp.rline = rline_q;
  assign rsp.err   = err_q;

  assign biu_stb            = (state == REQ);
  assign biu_adri           = req_q.addr;  // word offset kept for wrap
  assign biu_be             = line_op ? '1 : req_q.be;
  assign biu_type           = line_op ? HBURST_WRAP4 : HBURST_SINGLE;
  assign biu_we             = (req_q.op == OP_WRITEBACK) || (req_q.op == OP_WRITE);
  assign biu_di             = req_q.wline[wptr*XLEN +: XLEN];
  assign biu_is_cacheable   = req_q.cacheable;
  assign biu_is_instruction = req_q.is_instruction;
  assign biu_prv            = req_q.prv;

  // beat acknowledges and bus errors only arrive inside a burst
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    (biu_rack || biu_wack || biu_err) |-> state == BEATS);

endmodule
